// ==== bench/captiveBaseTb.sv ====
//----------------------------------------
// Testbench on a 16x8 screen, four layers
// Config batches land early in frames 0..2
// Every vde pop is one pixel, no underrun
//----------------------------------------
`timescale 1ns/1ps

module captiveBaseTb;

    localparam int hDisp      = 16;
    localparam int vDisp      = 8;
    localparam int layerCount = 4;
    localparam int framePix   = hDisp * vDisp;
    localparam int frameCount = 4;
    localparam int totalPix   = frameCount * framePix;
    // pclk cycles with vde low after run, lets the FIFO fill
    localparam int idleCycles = 40;
    // Two pclk per pixel, two bclk per pclk, doubled for vde gaps, plus startup
    localparam int cycleLimit = totalPix * 2 * 2 * 2 + 1000;

    // Model of one layer's settings
    typedef struct packed {
        logic [11:0] x0;
        logic [11:0] y0;
        logic [11:0] w;
        logic [11:0] h;
        logic        en;
        logic [23:0] col;
    } rectT;

    logic                            bclk = 1'b0;
    logic                            pclk = 1'b0;
    logic                            rst;
    logic                            run;
    logic                            cfgWe;
    logic [layerPkg::layerIdxW-1:0]  cfgLayer;
    layerPkg::cfgFieldT              cfgField;
    logic [layerPkg::cfgDataW-1:0]   cfgData;
    logic                            vde;
    logic [23:0]                     rgb;
    logic                            underrun;

    integer seed;
    int     outCount = 0;
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;
    rectT   live [layerCount];
    // Settings in force per frame, indexed [frame][layer]
    rectT   frameCfg [frameCount][layerCount];

    captiveBase #(
        .hDisplay   (hDisp),
        .vDisplay   (vDisp),
        .layerCount (layerCount),
        .fifoDepth  (16)
    ) i_dut (
        .bclk     (bclk),     .pclk     (pclk),
        .rst      (rst),      .run      (run),
        .cfgWe    (cfgWe),    .cfgLayer (cfgLayer),
        .cfgField (cfgField), .cfgData  (cfgData),
        .vde      (vde),      .rgb      (rgb),
        .underrun (underrun)
    );

    always #10 bclk = ~bclk;
    always #20 pclk = ~pclk;

    //----------------------------------------
    // Helpers
    //----------------------------------------
    function automatic int rnd(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fffffff) % n;
    endfunction

    function automatic rectT makeRect(input int x0, input int y0, input int w,
                                      input int h, input bit en);
        rectT r;
        r.x0  = 12'(x0);
        r.y0  = 12'(y0);
        r.w   = 12'(w);
        r.h   = 12'(h);
        r.en  = en;
        r.col = 24'($random(seed));
        return r;
    endfunction

    // Highest layer whose rectangle holds the pixel, else background
    function automatic logic [23:0] expectPix(input int n);
        int          f, x, y, x0, y0, w, h;
        logic [23:0] c;
        f = n / framePix;
        x = (n % framePix) % hDisp;
        y = (n % framePix) / hDisp;
        c = videoPkg::bgColor;
        for (int i = 0; i < layerCount; i++)
        begin
            x0 = frameCfg[f][i].x0;
            y0 = frameCfg[f][i].y0;
            w  = frameCfg[f][i].w;
            h  = frameCfg[f][i].h;
            if (frameCfg[f][i].en && x >= x0 && x < x0 + w && y >= y0 && y < y0 + h)
                c = frameCfg[f][i].col;
        end
        return c;
    endfunction

    // Called just after a bclk edge, leaves one write strobe
    task automatic writeCfg(input int idx, input layerPkg::cfgFieldT f,
                            input logic [23:0] d);
        cfgWe    = 1'b1;
        cfgLayer = layerPkg::layerIdxW'(idx);
        cfgField = f;
        cfgData  = d;
        @(posedge bclk);
        #2;
        cfgWe = 1'b0;
    endtask

    task automatic configLayer(input int idx, input rectT r);
        live[idx] = r;
        writeCfg(idx, layerPkg::fieldX0, 24'(r.x0));
        writeCfg(idx, layerPkg::fieldY0, 24'(r.y0));
        writeCfg(idx, layerPkg::fieldWidth, 24'(r.w));
        writeCfg(idx, layerPkg::fieldHeight, 24'(r.h));
        writeCfg(idx, layerPkg::fieldColor, r.col);
        writeCfg(idx, layerPkg::fieldEnable, {23'd0, r.en});
    endtask

    task automatic waitOutput(input int target);
        @(posedge bclk);
        while (outCount < target)
            @(posedge bclk);
        #2;
    endtask

    task automatic reportAndFinish();
        $display("Checks: %0d, errors: %0d, pixels: %0d", checks, errors, outCount);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    endtask

    //----------------------------------------
    // Reset, run and config batches
    //----------------------------------------
    initial
    begin
        int bx, by;
        seed     = 32'hf1b23fec;
        rst      = 1'b1;
        run      = 1'b0;
        cfgWe    = 1'b0;
        cfgLayer = '0;
        cfgField = layerPkg::fieldX0;
        cfgData  = '0;
        vde      = 1'b0;
        // Frame 0 runs with every layer off
        for (int f = 0; f < frameCount; f++)
            for (int i = 0; i < layerCount; i++)
                frameCfg[f][i] = '0;
        repeat (3) @(posedge bclk);
        #2;
        rst = 1'b0;
        @(posedge bclk);
        #2;
        run = 1'b1;

        // Frame 1, one rectangle cut by the right edge
        waitOutput(8);
        configLayer(0, makeRect(9 + rnd(5), rnd(4), 8 + rnd(4), 3 + rnd(6), 1'b1));
        for (int i = 1; i < layerCount; i++)
            configLayer(i, makeRect(rnd(16), rnd(8), 1 + rnd(8), 1 + rnd(8), 1'b0));
        for (int i = 0; i < layerCount; i++)
            frameCfg[1][i] = live[i];

        // Frame 2, stacked overlapping rectangles
        waitOutput(framePix + 8);
        bx = rnd(6);
        by = rnd(3);
        for (int i = 0; i < layerCount; i++)
            configLayer(i, makeRect(bx + i + rnd(2), by + rnd(2), 4 + rnd(6), 3 + rnd(4), 1'b1));
        for (int i = 0; i < layerCount; i++)
            frameCfg[2][i] = live[i];

        // Frame 3, anything goes
        waitOutput(2 * framePix + 8);
        for (int i = 0; i < layerCount; i++)
            configLayer(i, makeRect(rnd(18), rnd(10), 1 + rnd(12), 1 + rnd(8), rnd(4) != 0));
        for (int i = 0; i < layerCount; i++)
            frameCfg[3][i] = live[i];
    end

    //----------------------------------------
    // Output side, sampled 2 ns after pclk
    //----------------------------------------
    initial
    begin
        logic [23:0] exp;
        wait (rst === 1'b0);
        @(posedge pclk);
        #2;
        checks++;
        if (rgb !== 24'h0 || underrun !== 1'b0)
        begin
            $display("Mismatch at %0t: rgb/underrun expected 000000/0 actual %06h/%0b",
                     $time, rgb, underrun);
            errors++;
        end
        wait (run === 1'b1);
        // Nothing may leak out while vde is low
        repeat (idleCycles)
        begin
            @(posedge pclk);
            #2;
            checks++;
            if (rgb !== 24'h0)
            begin
                $display("Mismatch at %0t: rgb expected 000000 actual %06h", $time, rgb);
                errors++;
            end
        end
        while (outCount < totalPix)
        begin
            @(posedge pclk);
            #2;
            // vde as sampled on this edge popped one pixel
            if (vde)
            begin
                exp = expectPix(outCount);
                checks++;
                if (rgb !== exp)
                begin
                    $display("Mismatch at %0t: rgb pixel %0d expected %06h actual %06h",
                             $time, outCount, exp, rgb);
                    errors++;
                end
                outCount++;
            end
            checks++;
            if (underrun !== 1'b0)
            begin
                $display("Mismatch at %0t: underrun expected 0 actual %0b", $time, underrun);
                errors++;
            end
            vde = (rnd(10) < 7);
        end
        vde = 1'b0;
        reportAndFinish();
    end

    // Run limit
    initial
    begin
        while (cycles < cycleLimit)
        begin
            @(posedge bclk);
            cycles++;
        end
        $display("Timeout: output stalled, %0d of %0d pixels seen after %0d bclk cycles",
                 outCount, totalPix, cycles);
        errors++;
        reportAndFinish();
    end

endmodule

// ==== build.f ====
logic/videoPkg.sv
logic/layerPkg.sv
logic/scanIf.sv
logic/cfgIf.sv
logic/scanPosGen.sv
logic/rectLayer.sv
logic/layerMixer.sv
logic/asyncPixFifo.sv
logic/captiveBase.sv
bench/captiveBaseTb.sv

// ==== logic/asyncPixFifo.sv ====
//----------------------------------------
// Dual-clock FIFO, Gray pointers, 2-FF sync
// fifoDepth must be a power of two, >= 4
// rst must cover an edge of both clocks
//----------------------------------------
`timescale 1ns/1ps

module asyncPixFifo #(
    parameter int  fifoDepth = 16,
    parameter type payloadT  = logic [23:0]
)(
    input  logic     bclk,
    input  logic     pclk,
    input  logic     rst,
    input  logic     wrReq,
    input  payloadT  wrData,
    input  logic     vde,
    output logic     full,
    output payloadT  rgb,
    output logic     underrun
);

    localparam int addrW = $clog2(fifoDepth);

    payloadT mem [fifoDepth];

    // Pointers carry one wrap bit above the address
    logic [addrW:0] wrBin, wrBinNext, wrGray;
    logic [addrW:0] rdBin, rdBinNext, rdGray;
    logic [addrW:0] rdGraySync1, rdGraySync2;
    logic [addrW:0] wrGraySync1, wrGraySync2;
    logic           wrEn, rdEn, empty;

    function automatic logic [addrW:0] bin2gray(input logic [addrW:0] bin);
        return bin ^ (bin >> 1);
    endfunction

    //----------------------------------------
    // Write side, bclk
    //----------------------------------------
    assign wrEn      = wrReq && !full;
    assign wrBinNext = wrBin + (addrW + 1)'(1);

    always_ff @(posedge bclk)
    begin
        if (rst)
        begin
            wrBin       <= '0;
            wrGray      <= '0;
            rdGraySync1 <= '0;
            rdGraySync2 <= '0;
        end
        else
        begin
            if (wrEn)
            begin
                wrBin  <= wrBinNext;
                wrGray <= bin2gray(wrBinNext);
            end
            rdGraySync1 <= rdGray;
            rdGraySync2 <= rdGraySync1;
        end
    end

    always_ff @(posedge bclk)
    begin
        if (wrEn)
            mem[wrBin[addrW-1:0]] <= wrData;
    end

    // Full when the top two Gray bits differ and the rest match
    assign full = (wrGray == {~rdGraySync2[addrW:addrW-1], rdGraySync2[addrW-2:0]});

    //----------------------------------------
    // Read side, pclk
    //----------------------------------------
    assign empty     = (rdGray == wrGraySync2);
    assign rdEn      = vde && !empty;
    assign rdBinNext = rdBin + (addrW + 1)'(1);

    always_ff @(posedge pclk)
    begin
        if (rst)
        begin
            rdBin       <= '0;
            rdGray      <= '0;
            wrGraySync1 <= '0;
            wrGraySync2 <= '0;
            rgb         <= '0;
            underrun    <= 1'b0;
        end
        else
        begin
            if (rdEn)
            begin
                rgb    <= mem[rdBin[addrW-1:0]];
                rdBin  <= rdBinNext;
                rdGray <= bin2gray(rdBinNext);
            end
            // Sticky until reset
            if (vde && empty)
                underrun <= 1'b1;
            wrGraySync1 <= wrGray;
            wrGraySync2 <= wrGraySync1;
        end
    end

endmodule

// ==== logic/captiveBase.sv ====
//----------------------------------------
// Game screen pixel source, bclk to pclk
// FIFO full stalls the whole bclk pipeline
// rst must cover an edge of both clocks
//----------------------------------------
`timescale 1ns/1ps

module captiveBase #(
    parameter int hDisplay   = 640,
    parameter int vDisplay   = 480,
    parameter int layerCount = 4,
    parameter int fifoDepth  = 16
)(
    input  logic                            bclk,
    input  logic                            pclk,
    input  logic                            rst,
    input  logic                            run,
    // Layer configuration strobe
    input  logic                            cfgWe,
    input  logic [layerPkg::layerIdxW-1:0]  cfgLayer,
    input  layerPkg::cfgFieldT              cfgField,
    input  logic [layerPkg::cfgDataW-1:0]   cfgData,
    // Display side
    input  logic                            vde,
    output logic [23:0]                     rgb,
    output logic                            underrun
);

    scanIf pos ();
    cfgIf  cfg ();

    logic                    cke;
    logic                    fifoFull;
    logic [layerCount-1:0]   layerHit;
    videoPkg::pixelT         layerColor [layerCount];
    videoPkg::pixelT         mixPixel;
    logic                    mixWrReq;
    videoPkg::pixelT         fifoRgb;

    // Whole base domain holds while the FIFO is full
    assign cke = ~fifoFull;

    assign cfg.we    = cfgWe;
    assign cfg.layer = cfgLayer;
    assign cfg.field = cfgField;
    assign cfg.data  = cfgData;

    scanPosGen #(
        .hDisplay (hDisplay),
        .vDisplay (vDisplay)
    ) i_scanPosGen (
        .bclk (bclk), .rst (rst), .run (run), .cke (cke), .pos (pos)
    );

    //----------------------------------------
    // Rectangle layers
    //----------------------------------------
    for (genvar i = 0; i < layerCount; i++)
    begin : g_layer
        rectLayer #(
            .layerIdx (i)
        ) i_rectLayer (
            .bclk  (bclk),        .rst   (rst),
            .cke   (cke),         .cfg   (cfg),
            .pos   (pos),         .hit   (layerHit[i]),
            .color (layerColor[i])
        );
    end

    layerMixer #(
        .layerCount (layerCount)
    ) i_layerMixer (
        .bclk   (bclk),       .rst    (rst),
        .cke    (cke),        .pos    (pos),
        .hits   (layerHit),   .colors (layerColor),
        .pixel  (mixPixel),   .wrReq  (mixWrReq)
    );

    asyncPixFifo #(
        .fifoDepth (fifoDepth),
        .payloadT  (videoPkg::pixelT)
    ) i_asyncPixFifo (
        .bclk   (bclk),       .pclk     (pclk),
        .rst    (rst),        .wrReq    (mixWrReq),
        .wrData (mixPixel),   .vde      (vde),
        .full   (fifoFull),   .rgb      (fifoRgb),
        .underrun (underrun)
    );

    assign rgb = fifoRgb;

endmodule

// ==== logic/cfgIf.sv ====
//----------------------------------------
// Layer configuration write broadcast
// Single-cycle strobe, never refused
//----------------------------------------
`timescale 1ns/1ps

interface cfgIf;

    logic                             we;
    // Target layer index
    logic [layerPkg::layerIdxW-1:0]   layer;
    layerPkg::cfgFieldT               field;
    logic [layerPkg::cfgDataW-1:0]    data;

    modport master (output we, layer, field, data);
    modport slave  (input  we, layer, field, data);

endinterface

// ==== logic/layerMixer.sv ====
//----------------------------------------
// Highest hit layer wins, else background
// Output is the FIFO write side
//----------------------------------------
`timescale 1ns/1ps

module layerMixer #(
    parameter int layerCount = 4
)(
    input  logic               bclk,
    input  logic               rst,
    input  logic               cke,
    scanIf.sink                pos,
    input  logic [layerCount-1:0] hits,
    input  videoPkg::pixelT    colors [layerCount],
    output videoPkg::pixelT    pixel,
    output logic               wrReq
);

    // Valid aligned with the layer results
    logic             validD1;
    videoPkg::pixelT  selColor;

    // Later layers override earlier ones
    always_comb
    begin
        selColor = videoPkg::bgColor;
        for (int i = 0; i < layerCount; i++)
        begin
            if (hits[i])
                selColor = colors[i];
        end
    end

    //----------------------------------------
    // Output stage
    //----------------------------------------
    always_ff @(posedge bclk)
    begin
        if (rst)
        begin
            validD1 <= 1'b0;
            wrReq   <= 1'b0;
        end
        else if (cke)
        begin
            validD1 <= pos.valid;
            wrReq   <= validD1;
        end
    end

    // Held while stalled so the FIFO sees it again
    always_ff @(posedge bclk)
    begin
        if (cke)
            pixel <= selColor;
    end

endmodule

// ==== logic/layerPkg.sv ====
//----------------------------------------
// Scene control codes for rectangle layers
// Field codes 6 and 7 are ignored by layers
//----------------------------------------
package layerPkg;

    // Upper limit for the layer count
    localparam int maxLayers = 16;
    localparam int layerIdxW = $clog2(maxLayers);

    // Configuration field selector
    typedef enum logic [2:0] {
        fieldX0     = 3'd0,
        fieldY0     = 3'd1,
        fieldWidth  = 3'd2,
        fieldHeight = 3'd3,
        fieldColor  = 3'd4,
        fieldEnable = 3'd5
    } cfgFieldT;

    // One configuration word, wide enough for a pixel
    localparam int cfgDataW = 24;

endpackage

// ==== logic/rectLayer.sv ====
//----------------------------------------
// One rectangle layer, hit test registered
// Live config switches in at frame start
//----------------------------------------
`timescale 1ns/1ps

module rectLayer #(
    parameter int layerIdx = 0
)(
    input  logic              bclk,
    input  logic              rst,
    input  logic              cke,
    cfgIf.slave               cfg,
    scanIf.sink               pos,
    output logic              hit,
    output videoPkg::pixelT   color
);

    localparam int cw = videoPkg::coordW;
    localparam logic [layerPkg::layerIdxW-1:0] ownIdx = layerPkg::layerIdxW'(layerIdx);

    // Live set, written by config strobes
    logic [cw-1:0]    liveX0, liveY0, liveW, liveH;
    videoPkg::pixelT  liveColor;
    logic             liveEn;
    // Shadow set, used for the running frame
    logic [cw-1:0]    shX0, shY0, shW, shH;
    videoPkg::pixelT  shColor;
    logic             shEn;

    logic             frameSwap;
    logic [cw-1:0]    effX0, effY0, effW, effH;
    logic             inX, inY;

    //----------------------------------------
    // Live registers
    //----------------------------------------
    always_ff @(posedge bclk)
    begin
        if (rst)
            liveEn <= 1'b0;
        else if (cfg.we && cfg.layer == ownIdx && cfg.field == layerPkg::fieldEnable)
            liveEn <= cfg.data[0];
    end

    always_ff @(posedge bclk)
    begin
        if (cfg.we && cfg.layer == ownIdx)
        begin
            case (cfg.field)
                layerPkg::fieldX0:     liveX0    <= cfg.data[cw-1:0];
                layerPkg::fieldY0:     liveY0    <= cfg.data[cw-1:0];
                layerPkg::fieldWidth:  liveW     <= cfg.data[cw-1:0];
                layerPkg::fieldHeight: liveH     <= cfg.data[cw-1:0];
                layerPkg::fieldColor:  liveColor <= cfg.data;
                default: ;
            endcase
        end
    end

    //----------------------------------------
    // Shadow copy and hit test
    //----------------------------------------
    assign frameSwap = pos.valid && pos.frameStart;

    // First pixel of a frame sees the incoming values
    assign effX0 = frameSwap ? liveX0 : shX0;
    assign effY0 = frameSwap ? liveY0 : shY0;
    assign effW  = frameSwap ? liveW  : shW;
    assign effH  = frameSwap ? liveH  : shH;

    // One extra bit so edges past the screen do not wrap
    assign inX = ({1'b0, pos.x} >= {1'b0, effX0}) &&
                 ({1'b0, pos.x} <  ({1'b0, effX0} + {1'b0, effW}));
    assign inY = ({1'b0, pos.y} >= {1'b0, effY0}) &&
                 ({1'b0, pos.y} <  ({1'b0, effY0} + {1'b0, effH}));

    always_ff @(posedge bclk)
    begin
        if (rst)
        begin
            shEn <= 1'b0;
            hit  <= 1'b0;
        end
        else if (cke)
        begin
            if (frameSwap)
                shEn <= liveEn;
            hit <= pos.valid && (frameSwap ? liveEn : shEn) && inX && inY;
        end
    end

    always_ff @(posedge bclk)
    begin
        if (cke)
        begin
            if (frameSwap)
            begin
                shX0    <= liveX0;
                shY0    <= liveY0;
                shW     <= liveW;
                shH     <= liveH;
                shColor <= liveColor;
            end
            color <= frameSwap ? liveColor : shColor;
        end
    end

endmodule

// ==== logic/scanIf.sv ====
//----------------------------------------
// One scan position with its flags
// frameStart is only meaningful with valid
//----------------------------------------
`timescale 1ns/1ps

interface scanIf;

    // Raster coordinates
    logic [videoPkg::coordW-1:0] x;
    logic [videoPkg::coordW-1:0] y;
    // Position is (0,0)
    logic                        frameStart;
    logic                        valid;

    modport source (output x, y, frameStart, valid);
    modport sink   (input  x, y, frameStart, valid);

endinterface

// ==== logic/scanPosGen.sv ====
//----------------------------------------
// Raster position counter, one step per
// enabled cycle while run is high
//----------------------------------------
`timescale 1ns/1ps

module scanPosGen #(
    parameter int hDisplay = 640,
    parameter int vDisplay = 480
)(
    input  logic   bclk,
    input  logic   rst,
    input  logic   run,
    input  logic   cke,
    scanIf.source  pos
);

    // Last column and last line of the screen
    localparam logic [videoPkg::coordW-1:0] lastX = videoPkg::coordW'(hDisplay - 1);
    localparam logic [videoPkg::coordW-1:0] lastY = videoPkg::coordW'(vDisplay - 1);

    // Next position to be issued
    logic [videoPkg::coordW-1:0] cntX;
    logic [videoPkg::coordW-1:0] cntY;

    always_ff @(posedge bclk)
    begin
        if (rst)
        begin
            cntX           <= '0;
            cntY           <= '0;
            pos.x          <= '0;
            pos.y          <= '0;
            pos.frameStart <= 1'b0;
            pos.valid      <= 1'b0;
        end
        else if (cke)
        begin
            // Valid tracks run one stage later
            pos.valid <= run;
            if (run)
            begin
                pos.x          <= cntX;
                pos.y          <= cntY;
                pos.frameStart <= (cntX == '0) && (cntY == '0);
                // Step along the line, wrap at the end
                if (cntX == lastX)
                begin
                    cntX <= '0;
                    cntY <= (cntY == lastY) ? '0 : cntY + 1'b1;
                end
                else
                begin
                    cntX <= cntX + 1'b1;
                end
            end
        end
    end

endmodule

// ==== logic/videoPkg.sv ====
//----------------------------------------
// Picture description shared by all stages
// Coordinates are unsigned, 12 bits max
//----------------------------------------
package videoPkg;

    // Width of x and y screen coordinates
    localparam int coordW = 12;

    // One RGB pixel, 8 bits per channel
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } pixelT;

    // Shown where no layer is hit
    localparam pixelT bgColor = '{
        red:   8'h10,
        green: 8'h20,
        blue:  8'h40
    };

endpackage
